// File: miniCpuPkg.sv
`default_nettype none

package miniCpuPkg;

    localparam int DataWidth = 32;
    localparam int AddrWidth = 9;
    localparam int MemDepth  = 512;
    localparam int RegCount  = 16;

    // IR field positions
    localparam int OpcodeMsb = 31;
    localparam int OpcodeLsb = 27;
    localparam int RaMsb     = 26;
    localparam int RaLsb     = 23;
    localparam int RbMsb     = 22;
    localparam int RbLsb     = 19;
    localparam int RcMsb     = 18;
    localparam int RcLsb     = 15;
    localparam int ConstMsb  = 18; // C field is bits ConstMsb..0

    typedef logic [DataWidth-1:0] dataWordT;
    typedef logic [AddrWidth-1:0] memAddrT;
    typedef logic [3:0]           regIdxT;

    // ALU opcodes where unlisted codes give a zero result
    typedef enum logic [4:0] {
        Add = 5'd3,
        Sub = 5'd4,
        And = 5'd5,
        Or  = 5'd6,
        Shr = 5'd7,
        Shl = 5'd9,
        Mul = 5'd14,
        Neg = 5'd15,
        Not = 5'd16
    } aluOpT;

    // Z register halves with hi nonzero only after multiply
    typedef struct packed {
        dataWordT hi;
        dataWordT lo;
    } zPairT;

endpackage

`default_nettype wire

// File: cpuCtrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface cpuCtrlIf;
    import miniCpuPkg::*;

    logic HIout, LOout, ZhiOut, ZloOut, PCout, MDRout, Cout, Rout, BAout; // Bus sources
    logic HIin, LOin, PCin, IRin, Yin, Zin, MARin, MDRin, Rin;          // Load strobes
    logic Gra, Grb, Grc;                                                // IR field selects
    logic IncPC;
    aluOpT opcode;
    logic MemRead, MemWrite;
    dataWordT busWord;                                                  // Shared bus

    modport drive (
        output HIout, LOout, ZhiOut, ZloOut, PCout, MDRout, Cout, Rout, BAout,
        output HIin, LOin, PCin, IRin, Yin, Zin, MARin, MDRin, Rin,
        output Gra, Grb, Grc, IncPC, opcode, MemRead, MemWrite,
        input  busWord
    );

    modport bank (
        input HIout, LOout, PCout, Rout, BAout,
        input HIin, LOin, PCin, IRin, Rin,
        input Gra, Grb, Grc, busWord
    );

    modport alu (input Yin, Zin, IRin, IncPC, opcode, busWord);

    modport mem (input MARin, MDRin, MemRead, MemWrite, busWord);

    modport comb (input ZhiOut, ZloOut, Cout, MDRout, output busWord);

endinterface

`default_nettype wire

// File: regBank.sv
`timescale 1ns/1ps
`default_nettype none

module regBank (
    input  logic                 Clock,
    input  logic                 rstN,
    cpuCtrlIf.bank               ctrl,
    output miniCpuPkg::dataWordT regSource,
    output logic                 regSourceValid
);
    import miniCpuPkg::*;

    dataWordT regFile [RegCount];
    dataWordT pcReg;
    dataWordT irReg;
    dataWordT hiReg;
    dataWordT loReg;

    regIdxT   raField;
    regIdxT   rbField;
    regIdxT   rcField;
    regIdxT   selIdx;
    dataWordT selWord;
    logic     regDrive;

    assign raField = irReg[RaMsb:RaLsb];
    assign rbField = irReg[RbMsb:RbLsb];
    assign rcField = irReg[RcMsb:RcLsb];

    // Register number from the IR field picked by Gra, Grb or Grc
    assign selIdx = ({4{ctrl.Gra}} & raField)
                  | ({4{ctrl.Grb}} & rbField)
                  | ({4{ctrl.Grc}} & rcField);

    // r0 reads as zero under BAout
    always_comb begin
        if (ctrl.BAout && selIdx == '0) begin
            selWord = '0;
        end else begin
            selWord = regFile[selIdx];
        end
    end

    assign regDrive = ctrl.Rout | ctrl.BAout;

    assign regSource = ({DataWidth{regDrive}}   & selWord)
                     | ({DataWidth{ctrl.PCout}} & pcReg)
                     | ({DataWidth{ctrl.HIout}} & hiReg)
                     | ({DataWidth{ctrl.LOout}} & loReg);

    assign regSourceValid = regDrive | ctrl.PCout | ctrl.HIout | ctrl.LOout;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < RegCount; i++) begin
                regFile[i] <= '0;
            end
            pcReg <= '0;
            irReg <= '0;
            hiReg <= '0;
            loReg <= '0;
        end else begin
            if (ctrl.Rin) begin
                regFile[selIdx] <= ctrl.busWord; // Destination from IR field
            end
            if (ctrl.PCin) begin
                pcReg <= ctrl.busWord;
            end
            if (ctrl.IRin) begin
                irReg <= ctrl.busWord;
            end
            if (ctrl.HIin) begin
                hiReg <= ctrl.busWord;
            end
            if (ctrl.LOin) begin
                loReg <= ctrl.busWord;
            end
        end
    end

endmodule

`default_nettype wire

// File: aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  logic                 Clock,
    input  logic                 rstN,
    cpuCtrlIf.alu                ctrl,
    output miniCpuPkg::zPairT    zPair,
    output miniCpuPkg::dataWordT cSext
);
    import miniCpuPkg::*;

    dataWordT yReg;
    zPairT    zReg;
    dataWordT irCopy;   // Local IR copy for the C field
    zPairT    aluResult;
    dataWordT busIn;
    logic [4:0] shiftAmount;

    assign busIn       = ctrl.busWord;
    assign shiftAmount = busIn[4:0];

    always_comb begin
        aluResult = '0;
        if (ctrl.IncPC) begin
            aluResult.lo = busIn + 1'b1; // PC increment wins over opcode
        end else begin
            case (ctrl.opcode)
                Add: aluResult.lo = yReg + busIn;
                Sub: aluResult.lo = yReg - busIn;
                And: aluResult.lo = yReg & busIn;
                Or:  aluResult.lo = yReg | busIn;
                Shr: aluResult.lo = yReg >> shiftAmount; // Logical
                Shl: aluResult.lo = yReg << shiftAmount;
                Neg: aluResult.lo = -busIn;
                Not: aluResult.lo = ~busIn;
                Mul: begin
                    // Signed product spans both halves
                    {aluResult.hi, aluResult.lo} = $signed(yReg) * $signed(busIn);
                end
                default: aluResult = '0;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            yReg   <= '0;
            zReg   <= '0;
            irCopy <= '0;
        end else begin
            if (ctrl.Yin) begin
                yReg <= busIn;
            end
            if (ctrl.Zin) begin
                zReg <= aluResult;
            end
            if (ctrl.IRin) begin
                irCopy <= busIn;
            end
        end
    end

    assign zPair = zReg;
    assign cSext = {{(DataWidth - ConstMsb - 1){irCopy[ConstMsb]}}, irCopy[ConstMsb:0]};

endmodule

`default_nettype wire

// File: memUnit.sv
`timescale 1ns/1ps
`default_nettype none

module memUnit (
    input  logic                 Clock,
    input  logic                 rstN,
    cpuCtrlIf.mem                ctrl,
    input  logic                 memLoad,
    input  miniCpuPkg::memAddrT  loadAddress,
    input  miniCpuPkg::dataWordT loadData,
    output miniCpuPkg::dataWordT mdrWord,
    output miniCpuPkg::memAddrT  marAddress
);
    import miniCpuPkg::*;

    dataWordT memArray [MemDepth];
    memAddrT  marReg;
    dataWordT mdrReg;
    dataWordT readWord;

    assign readWord = memArray[marReg]; // Async read at current MAR

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            marReg <= '0;
            mdrReg <= '0;
        end else begin
            if (ctrl.MARin) begin
                marReg <= ctrl.busWord[AddrWidth-1:0]; // Low bits only
            end
            if (ctrl.MDRin) begin
                if (ctrl.MemRead) begin
                    mdrReg <= readWord;
                end else begin
                    mdrReg <= ctrl.busWord;
                end
            end
        end
    end

    // Preload port takes the write slot ahead of MemWrite
    always_ff @(posedge Clock) begin
        if (memLoad) begin
            memArray[loadAddress] <= loadData;
        end else if (ctrl.MemWrite) begin
            memArray[marReg] <= mdrReg;
        end
    end

    assign mdrWord    = mdrReg;
    assign marAddress = marReg;

endmodule

`default_nettype wire

// File: busCombiner.sv
`timescale 1ns/1ps
`default_nettype none

module busCombiner (
    cpuCtrlIf.comb               ctrl,
    input  miniCpuPkg::dataWordT regSource,
    input  logic                 regSourceValid,
    input  miniCpuPkg::zPairT    zPair,
    input  miniCpuPkg::dataWordT cSext,
    input  miniCpuPkg::dataWordT mdrWord
);
    import miniCpuPkg::*;

    dataWordT zhiTerm;
    dataWordT zloTerm;
    dataWordT cTerm;
    dataWordT mdrTerm;
    dataWordT bankTerm;

    // One-hot AND-OR mux with a zero idle bus
    assign zhiTerm  = {DataWidth{ctrl.ZhiOut}}    & zPair.hi;
    assign zloTerm  = {DataWidth{ctrl.ZloOut}}    & zPair.lo;
    assign cTerm    = {DataWidth{ctrl.Cout}}      & cSext;
    assign mdrTerm  = {DataWidth{ctrl.MDRout}}    & mdrWord;
    assign bankTerm = {DataWidth{regSourceValid}} & regSource;

    assign ctrl.busWord = zhiTerm | zloTerm | cTerm | mdrTerm | bankTerm;

endmodule

`default_nettype wire

// File: cpuDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpuDatapath (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 HIout,
    input  logic                 LOout,
    input  logic                 ZhiOut,
    input  logic                 ZloOut,
    input  logic                 PCout,
    input  logic                 MDRout,
    input  logic                 Cout,
    input  logic                 Rout,
    input  logic                 BAout,
    input  logic                 HIin,
    input  logic                 LOin,
    input  logic                 PCin,
    input  logic                 IRin,
    input  logic                 Yin,
    input  logic                 Zin,
    input  logic                 MARin,
    input  logic                 MDRin,
    input  logic                 Rin,
    input  logic                 Gra,
    input  logic                 Grb,
    input  logic                 Grc,
    input  logic                 IncPC,
    input  miniCpuPkg::aluOpT    opcode,
    input  logic                 MemRead,
    input  logic                 MemWrite,
    input  logic                 memLoad,
    input  miniCpuPkg::memAddrT  loadAddress,
    input  miniCpuPkg::dataWordT loadData,
    output miniCpuPkg::dataWordT busValue,
    output miniCpuPkg::memAddrT  marAddress
);
    import miniCpuPkg::*;

    cpuCtrlIf ctrl ();

    dataWordT regSource;
    logic     regSourceValid;
    zPairT    zPair;
    dataWordT cSext;
    dataWordT mdrWord;

    // Drive side of the control bundle
    assign ctrl.HIout    = HIout;
    assign ctrl.LOout    = LOout;
    assign ctrl.ZhiOut   = ZhiOut;
    assign ctrl.ZloOut   = ZloOut;
    assign ctrl.PCout    = PCout;
    assign ctrl.MDRout   = MDRout;
    assign ctrl.Cout     = Cout;
    assign ctrl.Rout     = Rout;
    assign ctrl.BAout    = BAout;
    assign ctrl.HIin     = HIin;
    assign ctrl.LOin     = LOin;
    assign ctrl.PCin     = PCin;
    assign ctrl.IRin     = IRin;
    assign ctrl.Yin      = Yin;
    assign ctrl.Zin      = Zin;
    assign ctrl.MARin    = MARin;
    assign ctrl.MDRin    = MDRin;
    assign ctrl.Rin      = Rin;
    assign ctrl.Gra      = Gra;
    assign ctrl.Grb      = Grb;
    assign ctrl.Grc      = Grc;
    assign ctrl.IncPC    = IncPC;
    assign ctrl.opcode   = opcode;
    assign ctrl.MemRead  = MemRead;
    assign ctrl.MemWrite = MemWrite;

    assign busValue = ctrl.busWord;

    regBank iRegBank (
        .Clock          (Clock),
        .rstN           (rstN),
        .ctrl           (ctrl.bank),
        .regSource      (regSource),
        .regSourceValid (regSourceValid)
    );

    aluUnit iAluUnit (
        .Clock (Clock),
        .rstN  (rstN),
        .ctrl  (ctrl.alu),
        .zPair (zPair),
        .cSext (cSext)
    );

    memUnit iMemUnit (
        .Clock       (Clock),
        .rstN        (rstN),
        .ctrl        (ctrl.mem),
        .memLoad     (memLoad),
        .loadAddress (loadAddress),
        .loadData    (loadData),
        .mdrWord     (mdrWord),
        .marAddress  (marAddress)
    );

    busCombiner iBusCombiner (
        .ctrl           (ctrl.comb),
        .regSource      (regSource),
        .regSourceValid (regSourceValid),
        .zPair          (zPair),
        .cSext          (cSext),
        .mdrWord        (mdrWord)
    );

endmodule

`default_nettype wire

// File: tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic Clock,
    output logic rstN
);

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock; // 10 ns period
    end

    // Reset spans 16 cycles and drops on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (16) @(negedge Clock);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: cpuDatapath_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cpuDatapath_asserts (
    input logic Clock,
    input logic rstN,
    input logic HIout, LOout, ZhiOut, ZloOut, PCout, MDRout, Cout, Rout, BAout,
    input logic MDRin, MemRead, MemWrite, memLoad
);

    logic [8:0] outStrobes;
    int         assertFails = 0; // Failed assertion count

    assign outStrobes = {HIout, LOout, ZhiOut, ZloOut, PCout, MDRout, Cout, Rout, BAout};

    // Shared bus has one source per cycle
    assert property (@(posedge Clock) disable iff (!rstN) $countones(outStrobes) <= 1)
        else begin
            $error("More than one out strobe is high in the same cycle");
            assertFails++;
        end

    assert property (@(posedge Clock) disable iff (!rstN) MemRead |-> MDRin)
        else begin
            $error("MemRead is high without MDRin");
            assertFails++;
        end

    assert property (@(posedge Clock) !(memLoad && MemWrite)) // Write port conflict
        else begin
            $error("memLoad and MemWrite are high together");
            assertFails++;
        end

endmodule

bind cpuDatapath cpuDatapath_asserts iAsserts (.*);

`default_nettype wire

// File: cpuDatapath_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuDatapath_tb;
    import miniCpuPkg::*;

    logic Clock, rstN;
    logic HIout, LOout, ZhiOut, ZloOut, PCout, MDRout, Cout, Rout, BAout;
    logic HIin, LOin, PCin, IRin, Yin, Zin, MARin, MDRin, Rin;
    logic Gra, Grb, Grc, IncPC, MemRead, MemWrite, memLoad;
    aluOpT       opcode;
    aluOpT       nextOp;       // Opcode applied with the next step
    memAddrT     loadAddress;
    dataWordT    loadData;
    dataWordT    busValue;
    memAddrT     marAddress;
    memAddrT     pcExp;
    logic [0:23] ctl;          // Same order as strobeNames
    string       testName;
    string       names[$];
    string       kinds[$];
    dataWordT    image[$];     // Instruction, opA, opB per record
    dataWordT    expLo[$];
    dataWordT    expHi[$];
    int          errors;
    int          checks;
    int          cycles;
    int          cycleLimit;

    string strobeNames [24] = '{
        "HIout", "LOout", "ZhiOut", "ZloOut", "PCout", "MDRout", "Cout", "Rout", "BAout",
        "HIin", "LOin", "PCin", "IRin", "Yin", "Zin", "MARin", "MDRin", "Rin",
        "Gra", "Grb", "Grc", "IncPC", "MemRead", "MemWrite"
    };

    assign {HIout, LOout, ZhiOut, ZloOut, PCout, MDRout, Cout, Rout, BAout,
            HIin, LOin, PCin, IRin, Yin, Zin, MARin, MDRin, Rin,
            Gra, Grb, Grc, IncPC, MemRead, MemWrite} = ctl;

    tbClock iClock (.Clock(Clock), .rstN(rstN));

    cpuDatapath i_dut (.*);

    always @(posedge Clock) begin
        cycles++;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Raises the listed strobes from this falling edge to the next one
    task automatic step(input string list);
        string padded;
        string pattern;
        padded = {" ", list, " "};
        @(negedge Clock);
        ctl = '0;
        opcode = nextOp;
        for (int k = 0; k < 24; k++) begin
            pattern = {" ", strobeNames[k], " "};
            for (int p = 0; p + pattern.len() <= padded.len(); p++) begin
                if (padded.substr(p, p + pattern.len() - 1) == pattern) begin
                    ctl[k] = 1'b1;
                end
            end
        end
        #2; // Bus settles well before the rising edge
    endtask

    task automatic checkBus(input dataWordT expected);
        checks++;
        if (busValue !== expected) begin
            errors++;
            $display("ERROR %s: bus expected %h, actual %h", testName, expected, busValue);
        end
    endtask

    task automatic checkAddress(input memAddrT expected);
        checks++;
        if (marAddress !== expected) begin
            errors++;
            $display("ERROR %s: MAR expected %h, actual %h", testName, expected, marAddress);
        end
    endtask

    // Z result of one opcode with Y from Ra and the bus word from Rb
    function automatic zPairT aluRule(input logic [4:0] op, input dataWordT y, input dataWordT b);
        zPairT z;
        logic signed [63:0] product;
        z = '0;
        product = $signed(y) * $signed(b);
        case (op)
            Add: z.lo = y + b;
            Sub: z.lo = y - b;
            And: z.lo = y & b;
            Or:  z.lo = y | b;
            Shr: z.lo = y >> b[4:0];
            Shl: z.lo = y << b[4:0];
            Neg: z.lo = 32'd0 - b;
            Not: z.lo = ~b;
            Mul: z = product;
            default: z = '0;
        endcase
        return z;
    endfunction

    // Fetch steps T0..T2 where T2 loads IR (dest 0), Ra (1) or Rb (2)
    task automatic fetchWord(input int dest, input dataWordT word);
        step("PCout MARin IncPC Zin");
        checkBus(dataWordT'(pcExp));
        step("ZloOut PCin MDRin MemRead");
        checkAddress(pcExp);
        case (dest)
            0: step("MDRout IRin");
            1: step("MDRout Gra Rin");
            default: step("MDRout Grb Rin");
        endcase
        checkBus(word);
        pcExp++;
    endtask

    task automatic loadImmediate(input dataWordT expected);
        step("Grb BAout Yin");
        step("Cout Zin");
        step("ZloOut HIin LOin");
        step("HIout");
        checkBus(expected);
        step("LOout");
        checkBus(expected);
    endtask

    task automatic moveFromHiLo(input logic useHi, input dataWordT expected);
        if (useHi) begin
            step("Grb Rout HIin");
            step("HIout Gra Rin");
        end else begin
            step("Grb Rout LOin");
            step("LOout Gra Rin");
        end
        step("Gra Rout");
        checkBus(expected);
    endtask

    task automatic aluOperation(input dataWordT instr, input dataWordT a, input dataWordT b,
                                input dataWordT fileLo, input dataWordT fileHi);
        zPairT expected;
        expected = aluRule(instr[OpcodeMsb:OpcodeLsb], a, b);
        if (expected !== {fileHi, fileLo}) begin
            errors++;
            $display("Record %s in the stimulus file disagrees with the opcode rules", testName);
        end
        step("Gra Rout Yin");
        nextOp = aluOpT'(instr[OpcodeMsb:OpcodeLsb]);
        step("Grb Rout Zin");
        nextOp = Add;
        step("ZloOut");
        checkBus(expected.lo);
        step("ZhiOut");
        checkBus(expected.hi);
    endtask

    task automatic memoryRoundTrip(input dataWordT word, input memAddrT address);
        step("Gra Rout MDRin");
        step("Cout MARin");
        step("MemWrite");
        checkAddress(address);
        step("Grb Rout MDRin"); // Overwrite MDR before the read back
        step("MDRin MemRead");
        step("MDRout");
        checkBus(word);
    endtask

    initial begin
        int fd;
        string line;
        string nm;
        string kd;
        dataWordT instr;
        dataWordT opA;
        dataWordT opB;
        dataWordT lo;
        dataWordT hi;
        int assertFails;
        ctl = '0;
        nextOp = Add;
        opcode = Add;
        memLoad = 1'b0;
        loadAddress = '0;
        loadData = '0;
        pcExp = '0;
        fd = $fopen("cpuDatapath_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open cpuDatapath_stim.txt for reading");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 2 && line[0] != "#") begin
                    void'($sscanf(line, "%s %s %h %h %h %h %h", nm, kd, instr, opA, opB, lo, hi));
                    names.push_back(nm);
                    kinds.push_back(kd);
                    image.push_back(instr);
                    image.push_back(opA);
                    image.push_back(opB);
                    expLo.push_back(lo);
                    expHi.push_back(hi);
                end
            end
            $fclose(fd);
        end
        // Reset, preload, 20 per record, margin
        cycleLimit = 16 + (3 * names.size() + 1) + 20 * names.size() + 8;

        wait (rstN === 1'b1);
        testName = "reset";
        step("PCout");
        checkBus('0);
        step("");
        checkBus('0);
        checkAddress('0);

        foreach (image[i]) begin
            @(negedge Clock);
            memLoad = 1'b1;
            loadAddress = memAddrT'(i);
            loadData = image[i];
        end
        @(negedge Clock);
        memLoad = 1'b0;

        for (int r = 0; r < names.size(); r++) begin
            testName = names[r];
            fetchWord(0, image[3*r]);
            fetchWord(1, image[3*r+1]);
            fetchWord(2, image[3*r+2]);
            case (kinds[r])
                "fetch": ;
                "ldi": loadImmediate(expLo[r]);
                "mfhi": moveFromHiLo(1'b1, expLo[r]);
                "mflo": moveFromHiLo(1'b0, expLo[r]);
                "alu": aluOperation(image[3*r], image[3*r+1], image[3*r+2], expLo[r], expHi[r]);
                "mem": memoryRoundTrip(expLo[r], memAddrT'(expHi[r]));
                default: begin
                    errors++;
                    $display("Record %s has an unknown kind %s", testName, kinds[r]);
                end
            endcase
        end
        step("");

        assertFails = i_dut.iAsserts.assertFails;
        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cpuDatapath_stim.txt
# name kind instr opA opB expLo expHi, words in hex; opA and opB are loaded into Ra and Rb
# kinds: fetch ldi mfhi mflo alu mem; for mem, expHi holds the memory address from C
fetchPlain fetch 12345678 00000000 00000000 00000000 00000000
ldiPlusReg ldi 00900010 aaaa0001 00000100 00000110 00000000
ldiBaseZero ldi 0187fffb 00000001 deadbeef fffffffb 00000000
ldiNegConst ldi 022fffff 00000002 00000010 0000000f 00000000
moveHi mfhi 03380000 11111111 cafef00d cafef00d 00000000
moveLo mflo 04480000 22222222 0badc0de 0badc0de 00000000
aluAdd alu 18900000 7fffffff 00000001 80000000 00000000
aluSub alu 20900000 00000010 00000020 fffffff0 00000000
aluAnd alu 28900000 f0f0f0f0 0ff00ff0 00f000f0 00000000
aluOr alu 30900000 f0f0f0f0 0ff00ff0 fff0fff0 00000000
aluShr alu 38900000 80000000 00000004 08000000 00000000
aluShl alu 48900000 00000003 00000024 00000030 00000000
aluNeg alu 78900000 00000000 00000005 fffffffb 00000000
aluNot alu 80900000 00000000 0000ffff ffff0000 00000000
aluMulNeg alu 70900000 fffffffe 00000003 fffffffa ffffffff
aluMulWide alu 70900000 00010000 00010000 00000000 00000001
aluUnused alu 00900000 00000005 00000006 00000000 00000000
memMid mem 01a00150 5a5a1234 00000000 5a5a1234 00000150
memTop mem 02b7ffff 0f1e2d3c ffffffff 0f1e2d3c 000001ff

// File: filelist.f
miniCpuPkg.sv
cpuCtrlIf.sv
regBank.sv
aluUnit.sv
memUnit.sv
busCombiner.sv
cpuDatapath.sv
tbClock.sv
cpuDatapath_asserts.sv
cpuDatapath_tb.sv

// File: Bender.yml
package:
  name: mini_cpu_datapath

sources:
  - miniCpuPkg.sv
  - cpuCtrlIf.sv
  - regBank.sv
  - aluUnit.sv
  - memUnit.sv
  - busCombiner.sv
  - cpuDatapath.sv
  - target: test
    files:
      - tbClock.sv
      - cpuDatapath_asserts.sv
      - cpuDatapath_tb.sv
